//--- Bender.yml
package:
  name: xp_sym

sources:
  - source/xp_sym_pkg.sv
  - source/xp_symbol_map.sv
  - source/sym_fifo.sv
  - source/xp_token_seq.sv
  - source/xp_wb_regs.sv
  - source/xp_sym_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_xp_sym.sv

//--- dv/xp_sym_checks.svh
// reference mapping model and checks
`ifndef XP_SYM_CHECKS_SVH
`define XP_SYM_CHECKS_SVH

int error_count = 0;
int check_count = 0;
int model_err_syms = 0;   // popped symbols with a map error.

// model state in token order.
logic             model_xp9 = 1'b0;
min_len_e         model_min_len = CHAR_4;
win_size_e        model_win = WIN_4K;
logic [WIN_W-1:0] model_cache [4] = '{default: '0};
logic             model_prev_match = 1'b0;
logic [SYM_W-1:0] expected_q [$];

function automatic int log2_floor(input int value);
   int pos;
   pos = 0;
   while ((value >> (pos + 1)) != 0)
      pos++;
   return pos;
endfunction

// predicts one symbol record and advances the offset cache.
task automatic model_token(input tok_kind_e kind, input int len, input int ofs,
                           input int mtf_num);
   int m, base, olog, oxtr, shrt, lng, llog, lxtr, adj, smax, lmax, sel, j;
   logic lvld, es, el, mtf;
   logic [WIN_W-1:0] nc [4];
   logic [SYM_W-1:0] rec;
   if (kind == TOK_LIT) begin
      rec = SYM_W'(len & 255);
      model_prev_match = 1'b0;
   end else begin
      mtf  = (kind == TOK_MTF);
      m    = (model_min_len == CHAR_3 || (mtf && model_xp9)) ? 3 : 4;
      base = mtf ? 256 + 16 * mtf_num : 320;
      olog = mtf ? 0 : log2_floor(ofs);
      oxtr = mtf ? 0 : ofs - (1 << olog);
      lvld = 1'b0;
      lng  = 0;
      llog = 0;
      lxtr = 0;
      if (len < m + 15) begin
         shrt = base + 16 * olog + len - m;
      end else begin
         shrt = base + 16 * olog + 15;
         lvld = 1'b1;
         if (len < m + 248) begin
            lng = len - 15 - m;
         end else begin
            adj  = len - 246 - m;
            llog = log2_floor(adj);
            lng  = 232 + llog;
            lxtr = adj - (1 << llog);
         end
      end
      case (model_win)
         WIN_4K: begin
            smax = 527;
            lmax = 244;
         end
         WIN_8K: begin
            smax = 543;
            lmax = 245;
         end
         WIN_16K: begin
            smax = 559;
            lmax = 246;
         end
         default: begin
            smax = 591;
            lmax = 248;
         end
      endcase
      es = (shrt > smax);
      el = (lng > lmax);
      if (es)
         shrt = smax;
      if (el)
         lng = lmax;
      rec = {2'b0, 15'(lxtr), 15'(oxtr), 3'b0, 4'(llog), 4'(olog),
             el, es, lvld, 8'(lng), 10'(shrt)};
      if (mtf) begin
         sel = mtf_num;
         if (model_prev_match && model_xp9)
            sel = (mtf_num + 1) % 4;   // skips the offset just used.
         nc[0] = model_cache[sel];
         j = 1;
         for (int i = 0; i < 4; i++) begin
            if (i != sel) begin
               nc[j] = model_cache[i];
               j++;
            end
         end
      end else begin
         nc[0] = WIN_W'(ofs);
         nc[1] = model_cache[0];
         nc[2] = model_cache[1];
         nc[3] = model_cache[2];
      end
      model_cache = nc;
      model_prev_match = 1'b1;
   end
   expected_q.push_back(rec);
endtask

task automatic check_symbol(input string name, input logic [SYM_W-1:0] got,
                            input logic [SYM_W-1:0] exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
   end
endtask

task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
   end
endtask

task automatic check_level(input string name, input logic [LVL_W-1:0] got,
                           input logic [LVL_W-1:0] exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
   end
endtask

task automatic check_offset(input string name, input logic [WIN_W-1:0] got,
                            input logic [WIN_W-1:0] exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
   end
endtask

`endif

//--- dv/tb_xp_sym.sv
// xp symbol mapping testbench
`timescale 1ns/10ps
`default_nettype none

module tb_xp_sym;
   import xp_sym_pkg::*;

   localparam int TIMEOUT_CYCLES = 64;

   logic        clk;
   logic        rst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [2:0]  wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;

   `include "xp_sym_checks.svh"

   xp_sym_top i_xp_sym_top (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   always #50 clk = ~clk;

   task automatic finish_run();
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   endtask

   task automatic timeout_abort(input string what);
      error_count++;
      $display("timeout: %s", what);
      finish_run();
   endtask

   task automatic bus_idle();
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_cycle(input wb_addr_e adr, input logic we, input logic [31:0] data,
                            output logic [31:0] rdata);
      int cycles;
      @(negedge clk);   // one idle cycle between transfers.
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = data;
      cycles   = 0;
      @(negedge clk);
      while (!wb_ack) begin
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            timeout_abort("no Wishbone ack for a bus cycle");
         @(negedge clk);
      end
      rdata = wb_dat_r;
      bus_idle();
   endtask

   task automatic wb_write(input wb_addr_e adr, input logic [31:0] data);
      logic [31:0] unused;
      bus_cycle(adr, 1'b1, data, unused);
   endtask

   task automatic wb_read(input wb_addr_e adr, output logic [31:0] data);
      bus_cycle(adr, 1'b0, 32'b0, data);
   endtask

   task automatic set_config(input logic xp9, input min_len_e min_len, input win_size_e win);
      logic [31:0] ctrl;
      wb_write(REG_CTRL, {24'b0, win, 2'b0, min_len, xp9});
      model_xp9     = xp9;
      model_min_len = min_len;
      model_win     = win;
      wb_read(REG_CTRL, ctrl);
      check_reg("REG_CTRL", ctrl, {24'b0, win, 2'b0, min_len, xp9});
   endtask

   // polls REG_STATUS until the given bit has the given value.
   task automatic wait_status(input int bit_pos, input logic value, input string what);
      logic [31:0] status;
      int polls;
      polls = 0;
      wb_read(REG_STATUS, status);
      while (status[bit_pos] !== value) begin
         polls++;
         if (polls > TIMEOUT_CYCLES)
            timeout_abort(what);
         wb_read(REG_STATUS, status);
      end
   endtask

   task automatic send_token(input tok_kind_e kind, input int len, input int ofs,
                             input int mtf_num);
      if (kind == TOK_PTR)
         wb_write(REG_TOK_OFS, 32'(ofs));
      wb_write(REG_TOK_CMD, {12'b0, kind, 2'(mtf_num), 16'(len)});
      model_token(kind, len, ofs, mtf_num);
   endtask

   task automatic read_symbol();
      logic [31:0] lo, hi;
      logic [SYM_W-1:0] exp;
      wait_status(4, 1'b0, "symbol FIFO stayed empty after a token");
      wb_read(REG_SYM_LO, lo);
      wb_read(REG_SYM_HI, hi);
      if (expected_q.size() == 0) begin
         error_count++;
         $display("a symbol was read but the model expected none");
      end else begin
         exp = expected_q.pop_front();
         check_symbol("sym_record", {hi, lo}, exp);
         if ((exp[SYM_ERR_SHRT] || exp[SYM_ERR_LONG]) && model_err_syms < 255)
            model_err_syms++;
      end
   endtask

   task automatic check_cache();
      check_offset("mtf_ofs_0", i_xp_sym_top.i_xp_token_seq.mtf_ofs_0, model_cache[0]);
      check_offset("mtf_ofs_1", i_xp_sym_top.i_xp_token_seq.mtf_ofs_1, model_cache[1]);
      check_offset("mtf_ofs_2", i_xp_sym_top.i_xp_token_seq.mtf_ofs_2, model_cache[2]);
      check_offset("mtf_ofs_3", i_xp_sym_top.i_xp_token_seq.mtf_ofs_3, model_cache[3]);
   endtask

   task automatic run_token(input tok_kind_e kind, input int len, input int ofs,
                            input int mtf_num);
      send_token(kind, len, ofs, mtf_num);
      read_symbol();
      check_cache();
   endtask

   task automatic check_status_idle();
      logic [31:0] status;
      wb_read(REG_STATUS, status);
      check_reg("REG_STATUS", status, {16'b0, 8'(model_err_syms), 2'b0, 1'b0, 1'b1, 4'b0});
   endtask

   task automatic test_reset();
      logic [31:0] data;
      wb_read(REG_STATUS, data);
      check_level("sym_level", data[3:0], '0);
      check_reg("REG_STATUS", data, 32'h10);
      wb_read(REG_SYM_HI, data);
      check_reg("REG_SYM_HI", data, 32'b0);   // an empty read does not pop.
      check_status_idle();
   endtask

   task automatic test_literals();
      set_config(1'b1, CHAR_4, WIN_64K);
      run_token(TOK_PTR, 9, 1234, 0);
      repeat (3)
         run_token(TOK_LIT, int'($urandom % 256), 0, 0);
      run_token(TOK_MTF, 5, 0, 0);   // no index step after a literal.
   endtask

   task automatic test_pointers();
      int m, len, ofs;
      for (int k = 0; k < 2; k++) begin
         set_config(1'b0, k ? CHAR_3 : CHAR_4, WIN_64K);
         m = k ? 3 : 4;
         for (int i = 0; i < 12; i++) begin
            ofs = 1 + int'($urandom % 65535);
            case (i % 3)
               0:       len = m + int'($urandom % 15);
               1:       len = m + 15 + int'($urandom % 233);
               default: len = m + 248 + int'($urandom % (65536 - m - 248));
            endcase
            run_token(TOK_PTR, len, ofs, 0);
         end
      end
   endtask

   task automatic test_mtf();
      set_config(1'b1, CHAR_4, WIN_64K);
      run_token(TOK_PTR, 6, 11, 0);
      run_token(TOK_PTR, 7, 22, 0);
      run_token(TOK_PTR, 8, 33, 0);
      run_token(TOK_PTR, 9, 44, 0);
      run_token(TOK_MTF, 3 + int'($urandom % 20), 0, 1);
      run_token(TOK_MTF, 3 + int'($urandom % 20), 0, 3);   // index wraps to 0.
      run_token(TOK_LIT, 8'h41, 0, 0);
      run_token(TOK_MTF, 3 + int'($urandom % 20), 0, 2);
      run_token(TOK_MTF, 300, 0, 1);
      set_config(1'b0, CHAR_4, WIN_64K);
      run_token(TOK_PTR, 12, 555, 0);
      run_token(TOK_MTF, 4 + int'($urandom % 20), 0, 3);
   endtask

   task automatic test_clamps();
      set_config(1'b0, CHAR_4, WIN_4K);
      run_token(TOK_PTR, 5, 16'h2000, 0);
      run_token(TOK_PTR, 18, 16'h8000, 0);
      run_token(TOK_PTR, 40000, 3, 0);
      run_token(TOK_PTR, 7, 16'h0fff, 0);
      set_config(1'b0, CHAR_4, WIN_8K);
      run_token(TOK_PTR, 10, 16'h4000, 0);
      run_token(TOK_PTR, 20000, 16'h0100, 0);
      set_config(1'b0, CHAR_3, WIN_16K);
      run_token(TOK_PTR, 60000, 16'h3000, 0);
      set_config(1'b0, CHAR_4, WIN_64K);
      run_token(TOK_PTR, 65535, 16'hffff, 0);
      check_status_idle();
   endtask

   task automatic test_backpressure();
      logic [31:0] status;
      bit acked;
      set_config(1'b1, CHAR_3, WIN_64K);
      send_token(TOK_PTR, 5, 100, 0);
      send_token(TOK_LIT, 8'h41, 0, 0);
      send_token(TOK_MTF, 7, 0, 1);
      send_token(TOK_PTR, 300, 16'h1234, 0);
      send_token(TOK_PTR, 40000, 7, 0);
      send_token(TOK_LIT, 8'hc3, 0, 0);
      send_token(TOK_MTF, 20, 0, 3);
      send_token(TOK_PTR, 3, 1, 0);
      wait_status(5, 1'b1, "symbol FIFO never became full");
      wb_read(REG_STATUS, status);
      check_level("sym_level", status[3:0], LVL_W'(FIFO_DEPTH));
      wb_write(REG_TOK_OFS, 32'hfff0);
      // ninth token must stall, so the strobe is held and then withdrawn.
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = REG_TOK_CMD;
      wb_dat_w = {12'b0, TOK_PTR, 2'b0, 16'd18};
      acked    = 1'b0;
      for (int c = 0; c < 8 && !acked; c++) begin
         @(negedge clk);
         acked = wb_ack;
      end
      bus_idle();
      check_count++;
      if (acked) begin
         error_count++;
         $display("ninth token write was acknowledged while the FIFO was full");
      end
      read_symbol();
      send_token(TOK_PTR, 18, 16'hfff0, 0);
      repeat (8)
         read_symbol();
      check_cache();
      check_status_idle();
   endtask

   initial begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      void'($urandom(6345));
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      test_reset();
      test_literals();
      test_pointers();
      test_mtf();
      test_clamps();
      test_backpressure();
      finish_run();
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+dv
source/xp_sym_pkg.sv
source/xp_symbol_map.sv
source/sym_fifo.sv
source/xp_token_seq.sv
source/xp_wb_regs.sv
source/xp_sym_top.sv
dv/tb_xp_sym.sv

//--- source/sym_fifo.sv
// symbol record fifo
`timescale 1ns/10ps
`default_nettype none

module sym_fifo (
   input  wire logic                         clk,
   input  wire logic                         rst_n,
   input  wire logic                         push,
   input  wire logic [xp_sym_pkg::SYM_W-1:0] push_data,
   input  wire logic                         pop,
   output logic [xp_sym_pkg::SYM_W-1:0]      head,
   output logic [xp_sym_pkg::LVL_W-1:0]      level,
   output logic                              empty,
   output logic                              full
);
   import xp_sym_pkg::*;

   logic [SYM_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;

   assign head  = mem[rd_ptr];
   assign empty = (level == '0);
   assign full  = (level == LVL_W'(FIFO_DEPTH));

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two.
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            level <= level + 1'b1;
         else if (pop && !push)
            level <= level - 1'b1;
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

//--- source/xp_sym_pkg.sv
// xp symbol mapping definitions
`default_nettype none

package xp_sym_pkg;

   localparam int WIN_W     = 16;
   localparam int MTF_W     = 2;
   localparam int XTR_LEN_W = 4;
   localparam int XTR_W     = 15;
   localparam int SHRT_W    = 10;
   localparam int LONG_W    = 8;
   localparam int SYM_W     = 64;

   localparam int FIFO_DEPTH = 8;
   localparam int PTR_W      = $clog2(FIFO_DEPTH);
   localparam int LVL_W      = $clog2(FIFO_DEPTH + 1);   // 0 up to FIFO_DEPTH.

   // error flag positions in the symbol record.
   localparam int SYM_ERR_SHRT = 19;
   localparam int SYM_ERR_LONG = 20;

   localparam logic [SHRT_W-1:0] MAX_SHRT_4K  = 10'd527;
   localparam logic [SHRT_W-1:0] MAX_SHRT_8K  = 10'd543;
   localparam logic [SHRT_W-1:0] MAX_SHRT_16K = 10'd559;
   localparam logic [SHRT_W-1:0] MAX_SHRT_64K = 10'd591;

   localparam logic [LONG_W-1:0] MAX_LONG_4K  = 8'd244;
   localparam logic [LONG_W-1:0] MAX_LONG_8K  = 8'd245;
   localparam logic [LONG_W-1:0] MAX_LONG_16K = 8'd246;
   localparam logic [LONG_W-1:0] MAX_LONG_64K = 8'd248;

   typedef enum logic [1:0] {
      TOK_LIT = 2'd0,
      TOK_PTR = 2'd1,
      TOK_MTF = 2'd2
   } tok_kind_e;

   // unlisted codes act as 64k.
   typedef enum logic [3:0] {
      WIN_4K  = 4'd0,
      WIN_8K  = 4'd1,
      WIN_16K = 4'd2,
      WIN_64K = 4'd3
   } win_size_e;

   typedef enum logic {
      CHAR_4 = 1'b0,
      CHAR_3 = 1'b1
   } min_len_e;

   typedef enum logic [2:0] {
      REG_CTRL    = 3'd0,
      REG_TOK_OFS = 3'd1,
      REG_TOK_CMD = 3'd2,
      REG_SYM_LO  = 3'd3,
      REG_SYM_HI  = 3'd4,
      REG_STATUS  = 3'd5
   } wb_addr_e;

endpackage

`default_nettype wire

//--- source/xp_sym_top.sv
// xp symbol mapping top
`timescale 1ns/10ps
`default_nettype none

module xp_sym_top (
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire logic        wb_cyc,
   input  wire logic        wb_stb,
   input  wire logic        wb_we,
   input  wire logic [2:0]  wb_adr,   // word address.
   input  wire logic [31:0] wb_dat_w,
   output logic [31:0]      wb_dat_r,
   output logic             wb_ack
);
   import xp_sym_pkg::*;

   logic             xp9;
   min_len_e         min_len;
   win_size_e        win_size;
   logic             tok_push;
   tok_kind_e        tok_kind;
   logic [WIN_W-1:0] tok_len;
   logic [WIN_W-1:0] tok_ofs;
   logic [MTF_W-1:0] tok_mtf_num;
   logic             sym_push;
   logic [SYM_W-1:0] sym_data;
   logic             sym_pop;
   logic [SYM_W-1:0] sym_head;
   logic [LVL_W-1:0] sym_level;
   logic             sym_empty;
   logic             sym_full;
   logic             sym_err;

   assign sym_err = sym_head[SYM_ERR_SHRT] | sym_head[SYM_ERR_LONG];

   xp_wb_regs i_xp_wb_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_addr_e'(wb_adr)),
      .wb_dat_w    (wb_dat_w),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .sym_head    (sym_head),
      .sym_level   (sym_level),
      .sym_empty   (sym_empty),
      .sym_full    (sym_full),
      .sym_err     (sym_err),
      .xp9         (xp9),
      .min_len     (min_len),
      .win_size    (win_size),
      .tok_push    (tok_push),
      .tok_kind    (tok_kind),
      .tok_len     (tok_len),
      .tok_ofs     (tok_ofs),
      .tok_mtf_num (tok_mtf_num),
      .sym_pop     (sym_pop)
   );

   xp_token_seq i_xp_token_seq (
      .clk         (clk),
      .rst_n       (rst_n),
      .tok_push    (tok_push),
      .tok_kind    (tok_kind),
      .tok_len     (tok_len),
      .tok_ofs     (tok_ofs),
      .tok_mtf_num (tok_mtf_num),
      .xp9         (xp9),
      .min_len     (min_len),
      .win_size    (win_size),
      .sym_push    (sym_push),
      .sym_data    (sym_data)
   );

   sym_fifo i_sym_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (sym_push),
      .push_data (sym_data),
      .pop       (sym_pop),
      .head      (sym_head),
      .level     (sym_level),
      .empty     (sym_empty),
      .full      (sym_full)
   );

endmodule

`default_nettype wire

//--- source/xp_symbol_map.sv
// token to symbol mapper
`timescale 1ns/10ps
`default_nettype none

module xp_symbol_map (
   input  wire logic                             xp9,
   input  wire xp_sym_pkg::min_len_e             min_len,
   input  wire logic                             mtf,
   input  wire logic [xp_sym_pkg::MTF_W-1:0]     mtf_num,
   input  wire logic [xp_sym_pkg::WIN_W-1:0]     len,
   input  wire logic [xp_sym_pkg::WIN_W-1:0]     ofs,
   input  wire xp_sym_pkg::win_size_e            win_size,
   input  wire logic [xp_sym_pkg::WIN_W-1:0]     mtf_offset_0,
   input  wire logic [xp_sym_pkg::WIN_W-1:0]     mtf_offset_1,
   input  wire logic [xp_sym_pkg::WIN_W-1:0]     mtf_offset_2,
   input  wire logic [xp_sym_pkg::WIN_W-1:0]     mtf_offset_3,
   input  wire logic                             prev_match,
   output logic [xp_sym_pkg::SHRT_W-1:0]         shrt,
   output logic [xp_sym_pkg::LONG_W-1:0]         long,
   output logic                                  long_vld,
   output logic [xp_sym_pkg::XTR_LEN_W-1:0]      ofs_xtr_len,
   output logic [xp_sym_pkg::XTR_W-1:0]          ofs_xtr,
   output logic [xp_sym_pkg::XTR_LEN_W-1:0]      len_xtr_len,
   output logic [xp_sym_pkg::XTR_W-1:0]          len_xtr,
   output logic                                  map_error_shrt,
   output logic                                  map_error_long,
   output logic [xp_sym_pkg::WIN_W-1:0]          mtf_offset_out_0,
   output logic [xp_sym_pkg::WIN_W-1:0]          mtf_offset_out_1,
   output logic [xp_sym_pkg::WIN_W-1:0]          mtf_offset_out_2,
   output logic [xp_sym_pkg::WIN_W-1:0]          mtf_offset_out_3
);
   import xp_sym_pkg::*;

   logic [WIN_W:0]       min_val;   // effective minimum match.
   logic [SHRT_W-1:0]    base;
   logic [WIN_W:0]       shrt_pre;
   logic [WIN_W:0]       long_pre;
   logic [WIN_W:0]       len_adj;
   logic [SHRT_W-1:0]    shrt_max;
   logic [LONG_W-1:0]    long_max;
   logic [WIN_W-1:0]     cache [4];
   logic [MTF_W-1:0]     sel;

   function automatic logic [XTR_LEN_W-1:0] floor_log2(input logic [WIN_W-1:0] value);
      logic [XTR_LEN_W-1:0] pos;
      pos = '0;
      for (int j = 0; j < WIN_W; j++) begin
         if (value[j])
            pos = XTR_LEN_W'(j);
      end
      return pos;
   endfunction

   always_comb begin
      min_val     = (min_len == CHAR_3 || (mtf && xp9)) ? 17'd3 : 17'd4;
      base        = mtf ? (10'd256 + {4'b0, mtf_num, 4'b0}) : 10'd320;
      ofs_xtr_len = mtf ? '0 : floor_log2(ofs);
      ofs_xtr     = '0;
      if (ofs_xtr_len != 0)
         ofs_xtr = XTR_W'(ofs - (16'd1 << ofs_xtr_len));
      long_vld    = 1'b0;
      long_pre    = '0;
      len_adj     = '0;
      len_xtr_len = '0;
      len_xtr     = '0;

      if (len < min_val + 17'd15) begin
         shrt_pre = base + {ofs_xtr_len, 4'b0} + len - min_val;
      end else begin
         shrt_pre = base + {ofs_xtr_len, 4'b0} + 17'd15;
         long_vld = 1'b1;
         if (len < min_val + 17'd248) begin
            long_pre = len - 17'd15 - min_val;
         end else begin
            len_adj     = len - 17'd246 - min_val;
            len_xtr_len = floor_log2(len_adj[WIN_W-1:0]);
            long_pre    = 17'd232 + len_xtr_len;
            len_xtr     = XTR_W'(len_adj - (17'd1 << len_xtr_len));
         end
      end

      case (win_size)
         WIN_4K: begin
            shrt_max = MAX_SHRT_4K;
            long_max = MAX_LONG_4K;
         end
         WIN_8K: begin
            shrt_max = MAX_SHRT_8K;
            long_max = MAX_LONG_8K;
         end
         WIN_16K: begin
            shrt_max = MAX_SHRT_16K;
            long_max = MAX_LONG_16K;
         end
         default: begin
            shrt_max = MAX_SHRT_64K;
            long_max = MAX_LONG_64K;
         end
      endcase

      shrt           = shrt_pre[SHRT_W-1:0];
      long           = long_pre[LONG_W-1:0];
      map_error_shrt = shrt > shrt_max;
      map_error_long = long > long_max;
      if (map_error_shrt)
         shrt = shrt_max;
      if (map_error_long)
         long = long_max;
   end

   // offset cache rotation.
   always_comb begin
      cache[0] = mtf_offset_0;
      cache[1] = mtf_offset_1;
      cache[2] = mtf_offset_2;
      cache[3] = mtf_offset_3;
      sel      = mtf_num;
      if (prev_match && xp9)
         sel = mtf_num + 2'd1;   // wraps to entry 0.

      if (mtf) begin
         mtf_offset_out_0 = cache[sel];
         mtf_offset_out_1 = (sel > 2'd0) ? cache[0] : cache[1];
         mtf_offset_out_2 = (sel > 2'd1) ? cache[1] : cache[2];
         mtf_offset_out_3 = (sel > 2'd2) ? cache[2] : cache[3];
      end else begin
         mtf_offset_out_0 = ofs;
         mtf_offset_out_1 = cache[0];
         mtf_offset_out_2 = cache[1];
         mtf_offset_out_3 = cache[2];
      end
   end

endmodule

`default_nettype wire

//--- source/xp_token_seq.sv
// token sequencer and mtf cache
`timescale 1ns/10ps
`default_nettype none

module xp_token_seq (
   input  wire logic                         clk,
   input  wire logic                         rst_n,
   input  wire logic                         tok_push,
   input  wire xp_sym_pkg::tok_kind_e        tok_kind,
   input  wire logic [xp_sym_pkg::WIN_W-1:0] tok_len,
   input  wire logic [xp_sym_pkg::WIN_W-1:0] tok_ofs,
   input  wire logic [xp_sym_pkg::MTF_W-1:0] tok_mtf_num,
   input  wire logic                         xp9,
   input  wire xp_sym_pkg::min_len_e         min_len,
   input  wire xp_sym_pkg::win_size_e        win_size,
   output logic                              sym_push,
   output logic [xp_sym_pkg::SYM_W-1:0]      sym_data
);
   import xp_sym_pkg::*;

   logic                 valid_q;
   tok_kind_e            kind_q;
   logic [WIN_W-1:0]     len_q;
   logic [WIN_W-1:0]     ofs_q;
   logic [MTF_W-1:0]     mtf_num_q;
   logic                 prev_match;
   logic                 is_match;
   logic [WIN_W-1:0]     mtf_ofs_0, mtf_ofs_1, mtf_ofs_2, mtf_ofs_3;
   logic [WIN_W-1:0]     nxt_ofs_0, nxt_ofs_1, nxt_ofs_2, nxt_ofs_3;
   logic [SHRT_W-1:0]    map_shrt;
   logic [LONG_W-1:0]    map_long;
   logic                 map_long_vld;
   logic [XTR_LEN_W-1:0] map_ofs_xtr_len, map_len_xtr_len;
   logic [XTR_W-1:0]     map_ofs_xtr, map_len_xtr;
   logic                 map_err_shrt, map_err_long;

   assign is_match = (kind_q == TOK_PTR) || (kind_q == TOK_MTF);
   assign sym_push = valid_q;

   always_ff @(posedge clk) begin
      if (tok_push) begin
         kind_q    <= tok_kind;
         len_q     <= tok_len;
         ofs_q     <= tok_ofs;
         mtf_num_q <= tok_mtf_num;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q    <= 1'b0;
         prev_match <= 1'b0;
         mtf_ofs_0  <= '0;
         mtf_ofs_1  <= '0;
         mtf_ofs_2  <= '0;
         mtf_ofs_3  <= '0;
      end else begin
         valid_q <= tok_push;
         if (valid_q) begin
            prev_match <= is_match;
            if (is_match) begin   // literals keep the cache.
               mtf_ofs_0 <= nxt_ofs_0;
               mtf_ofs_1 <= nxt_ofs_1;
               mtf_ofs_2 <= nxt_ofs_2;
               mtf_ofs_3 <= nxt_ofs_3;
            end
         end
      end
   end

   xp_symbol_map i_xp_symbol_map (
      .xp9              (xp9),
      .min_len          (min_len),
      .mtf              (kind_q == TOK_MTF),
      .mtf_num          (mtf_num_q),
      .len              (len_q),
      .ofs              (ofs_q),
      .win_size         (win_size),
      .mtf_offset_0     (mtf_ofs_0),
      .mtf_offset_1     (mtf_ofs_1),
      .mtf_offset_2     (mtf_ofs_2),
      .mtf_offset_3     (mtf_ofs_3),
      .prev_match       (prev_match),
      .shrt             (map_shrt),
      .long             (map_long),
      .long_vld         (map_long_vld),
      .ofs_xtr_len      (map_ofs_xtr_len),
      .ofs_xtr          (map_ofs_xtr),
      .len_xtr_len      (map_len_xtr_len),
      .len_xtr          (map_len_xtr),
      .map_error_shrt   (map_err_shrt),
      .map_error_long   (map_err_long),
      .mtf_offset_out_0 (nxt_ofs_0),
      .mtf_offset_out_1 (nxt_ofs_1),
      .mtf_offset_out_2 (nxt_ofs_2),
      .mtf_offset_out_3 (nxt_ofs_3)
   );

   always_comb begin
      sym_data = '0;
      if (is_match)
         sym_data = {2'b0, map_len_xtr, map_ofs_xtr, 3'b0, map_len_xtr_len, map_ofs_xtr_len,
                     map_err_long, map_err_shrt, map_long_vld, map_long, map_shrt};
      else
         sym_data[SHRT_W-1:0] = {2'b0, len_q[7:0]};   // literal byte.
   end

   // match symbols sit above the literal byte range.
   a_sym_range: assert property (@(posedge clk) disable iff (!rst_n)
      sym_push |-> ((sym_data[SHRT_W-1:0] > 10'd255) == is_match));

endmodule

`default_nettype wire

//--- source/xp_wb_regs.sv
// wishbone register front end
`timescale 1ns/10ps
`default_nettype none

module xp_wb_regs (
   input  wire logic                         clk,
   input  wire logic                         rst_n,
   input  wire logic                         wb_cyc,
   input  wire logic                         wb_stb,
   input  wire logic                         wb_we,
   input  wire xp_sym_pkg::wb_addr_e         wb_adr,
   input  wire logic [31:0]                  wb_dat_w,
   output logic [31:0]                       wb_dat_r,
   output logic                              wb_ack,
   input  wire logic [xp_sym_pkg::SYM_W-1:0] sym_head,
   input  wire logic [xp_sym_pkg::LVL_W-1:0] sym_level,
   input  wire logic                         sym_empty,
   input  wire logic                         sym_full,
   input  wire logic                         sym_err,
   output logic                              xp9,
   output xp_sym_pkg::min_len_e              min_len,
   output xp_sym_pkg::win_size_e             win_size,
   output logic                              tok_push,
   output xp_sym_pkg::tok_kind_e             tok_kind,
   output logic [xp_sym_pkg::WIN_W-1:0]      tok_len,
   output logic [xp_sym_pkg::WIN_W-1:0]      tok_ofs,
   output logic [xp_sym_pkg::MTF_W-1:0]      tok_mtf_num,
   output logic                              sym_pop
);
   import xp_sym_pkg::*;

   logic        req;
   logic        wr;
   logic        tok_wr;
   logic        stall;
   logic        tok_pend;   // token still in the sequencer.
   logic [7:0]  err_cnt;
   logic [31:0] rd_data;

   assign req    = wb_cyc && wb_stb && !wb_ack;   // no new ack in the ack cycle.
   assign wr     = req && wb_we;
   assign tok_wr = wr && (wb_adr == REG_TOK_CMD);

   // back-pressure. a token in the sequencer also needs a slot.
   assign stall  = tok_wr && (sym_full ||
                   (tok_pend && (sym_level == LVL_W'(FIFO_DEPTH - 1))));

   // pop only on the high word, never on an empty fifo.
   assign sym_pop = req && !wb_we && (wb_adr == REG_SYM_HI) && !sym_empty;

   always_comb begin
      rd_data = '0;
      case (wb_adr)
         REG_CTRL:   rd_data = {24'b0, win_size, 2'b0, min_len, xp9};
         REG_SYM_LO: rd_data = sym_empty ? 32'b0 : sym_head[31:0];
         REG_SYM_HI: rd_data = sym_empty ? 32'b0 : sym_head[SYM_W-1:32];
         REG_STATUS: rd_data = {16'b0, err_cnt, 2'b0, sym_full, sym_empty, sym_level};
         default:    rd_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_ack   <= 1'b0;
         tok_push <= 1'b0;
         tok_pend <= 1'b0;
         xp9      <= 1'b0;
         min_len  <= CHAR_4;
         win_size <= WIN_4K;
         err_cnt  <= '0;
      end else begin
         wb_ack   <= req && !stall;
         tok_push <= tok_wr && !stall;
         tok_pend <= tok_push;
         if (wr && (wb_adr == REG_CTRL)) begin
            xp9      <= wb_dat_w[0];
            min_len  <= min_len_e'(wb_dat_w[1]);
            win_size <= win_size_e'(wb_dat_w[7:4]);
         end
         if (sym_pop && sym_err && (err_cnt != 8'hff))
            err_cnt <= err_cnt + 8'd1;   // saturates.
      end
   end

   always_ff @(posedge clk) begin
      if (wr && (wb_adr == REG_TOK_OFS))
         tok_ofs <= wb_dat_w[WIN_W-1:0];
      if (tok_wr && !stall) begin
         tok_len     <= wb_dat_w[15:0];
         tok_mtf_num <= wb_dat_w[17:16];
         tok_kind    <= tok_kind_e'(wb_dat_w[19:18]);
      end
      if (req && !wb_we)
         wb_dat_r <= rd_data;
   end

   // an accepted token finds a free fifo slot.
   a_token_room: assert property (@(posedge clk) disable iff (!rst_n)
      tok_push |=> !sym_full);

endmodule

`default_nettype wire
